/* compile.f */
+incdir+tests
design/trdb_pkg.sv
design/trdb_retire_stage.sv
design/trdb_branch_map.sv
design/trdb_packet_decide.sv
design/trdb_packet_fifo.sv
design/trdb_word_serializer.sv
design/trace_compressor.sv
tests/trdb_tb.sv

/* design/trace_compressor.sv */
////////////////////////////////////////
// trace compressor top level
// retire stage, branch map, decider,
// packet FIFO and word serializer
////////////////////////////////////////
module trace_compressor #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  trdb_pkg::trdb_instr_t instr_i,
    input  logic                  trace_enable_i,
    output logic [31:0]           word_o,
    output logic                  word_valid_o,
    input  logic                  word_ready_i,
    output logic                  overflow_o
);
    import trdb_pkg::*;

    trdb_retired_t             retired;
    logic [BRANCH_MAP_LEN-1:0] map;
    logic [4:0]                count;
    logic                      map_full;
    logic                      flush;
    logic                      pkt_valid;
    trdb_packet_t              pkt;
    logic                      head_valid;
    logic                      head_ready;
    trdb_packet_t              head_pkt;

    trdb_retire_stage u_retire_stage (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_i        (instr_i),
        .trace_enable_i (trace_enable_i),
        .retired_o      (retired)
    );

    trdb_branch_map u_branch_map (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .record_i (retired.record),
        .taken_i  (retired.taken),
        .flush_i  (flush),
        .map_o    (map),
        .count_o  (count),
        .full_o   (map_full)
    );

    trdb_packet_decide u_packet_decide (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .retired_i   (retired),
        .map_i       (map),
        .count_i     (count),
        .full_i      (map_full),
        .flush_o     (flush),
        .pkt_valid_o (pkt_valid),
        .pkt_o       (pkt)
    );

    trdb_packet_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_packet_fifo (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (pkt_valid),
        .pkt_i       (pkt),
        .pop_valid_o (head_valid),
        .pkt_o       (head_pkt),
        .pop_ready_i (head_ready),
        .overflow_o  (overflow_o)
    );

    trdb_word_serializer u_word_serializer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .pkt_valid_i  (head_valid),
        .pkt_i        (head_pkt),
        .pkt_ready_o  (head_ready),
        .word_o       (word_o),
        .word_valid_o (word_valid_o),
        .word_ready_i (word_ready_i)
    );

endmodule

/* design/trdb_branch_map.sv */
////////////////////////////////////////
// branch map: taken/not-taken bits
// and their count, record and flush
////////////////////////////////////////
module trdb_branch_map (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               record_i,
    input  logic                               taken_i,
    input  logic                               flush_i,
    output logic [trdb_pkg::BRANCH_MAP_LEN-1:0] map_o,
    output logic [4:0]                         count_o,
    output logic                               full_o
);
    import trdb_pkg::*;

    logic [BRANCH_MAP_LEN-1:0] map_q;
    logic [4:0]                count_q;

    // on record with flush the outcome already left inside the packet
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (record_i) begin
            map_q[count_q] <= taken_i;
            count_q        <= count_q + 5'd1;
        end
    end

    assign map_o   = map_q;
    assign count_o = count_q;
    assign full_o  = count_q == 5'(BRANCH_MAP_LEN);

    a_count_bound: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        count_q <= 5'(BRANCH_MAP_LEN)
    ) else $error("branch map count above %0d", BRANCH_MAP_LEN);

endmodule

/* design/trdb_packet_decide.sv */
////////////////////////////////////////
// packet decision: priority rules,
// payload view fill, packet register
////////////////////////////////////////
module trdb_packet_decide (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  trdb_pkg::trdb_retired_t             retired_i,
    input  logic [trdb_pkg::BRANCH_MAP_LEN-1:0] map_i,
    input  logic [4:0]                          count_i,
    input  logic                                full_i,
    output logic                                flush_o,
    output logic                                pkt_valid_o,
    output trdb_pkg::trdb_packet_t              pkt_o
);
    import trdb_pkg::*;

    // map as it will be once this cycle's outcome is in
    logic [BRANCH_MAP_LEN-1:0] map_view;
    logic [4:0]                count_view;
    logic                      full_view;

    logic                      emit;
    trdb_packet_t              pkt_d;

    always_comb begin
        map_view   = map_i;
        count_view = count_i;
        if (retired_i.record) begin
            map_view[count_i] = retired_i.taken;
            count_view        = count_i + 5'd1;
        end
        full_view = full_i || (retired_i.record && count_i == 5'(BRANCH_MAP_LEN - 1));
    end

    always_comb begin
        emit          = 1'b0;
        flush_o       = 1'b0;
        pkt_d.format  = F_BRANCH;
        pkt_d.payload = '0;
        pkt_d.addr    = retired_i.iaddr;
        if (retired_i.traced) begin
            if (retired_i.exception) begin
                // map stays for the next packet
                emit                        = 1'b1;
                pkt_d.format                = F_EXC;
                pkt_d.payload.exc.interrupt = retired_i.interrupt;
                pkt_d.payload.exc.cause     = retired_i.cause;
                pkt_d.payload.exc.priv      = retired_i.priv;
            end else if (retired_i.need_sync || retired_i.after_udisc || full_view) begin
                emit                        = 1'b1;
                flush_o                     = 1'b1;
                pkt_d.format                = retired_i.need_sync ? F_SYNC : F_BRANCH;
                pkt_d.payload.branch.count  = count_view;
                pkt_d.payload.branch.map    = map_view;
            end
        end
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            pkt_valid_o <= 1'b0;
        end else begin
            pkt_valid_o <= emit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (emit) begin
            pkt_o <= pkt_d;
        end
    end

    a_flush_format: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        flush_o |=> pkt_valid_o && pkt_o.format inside {F_SYNC, F_BRANCH}
    ) else $error("map flushed without a sync or branch packet");

endmodule

/* design/trdb_packet_fifo.sv */
////////////////////////////////////////
// packet FIFO, first word fall through
// drops pushes when full, sticky flag
////////////////////////////////////////
module trdb_packet_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   push_i,
    input  trdb_pkg::trdb_packet_t pkt_i,
    output logic                   pop_valid_o,
    output trdb_pkg::trdb_packet_t pkt_o,
    input  logic                   pop_ready_i,
    output logic                   overflow_o
);
    import trdb_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    trdb_packet_t     mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             overflow_q;

    logic             full;
    logic             write;
    logic             read;

    assign full        = count_q == CNT_W'(FIFO_DEPTH);
    assign write       = push_i && !full;
    assign read        = pop_valid_o && pop_ready_i;
    assign pop_valid_o = count_q != '0;
    assign pkt_o       = mem_q[rd_ptr_q];
    assign overflow_o  = overflow_q;

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (write) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (read) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(write) - CNT_W'(read);
            // set once, cleared only by reset
            if (push_i && full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (write) begin
            mem_q[wr_ptr_q] <= pkt_i;
        end
    end

    a_no_read_empty: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        count_q == '0 |=> $stable(rd_ptr_q)
    ) else $error("packet FIFO read while empty");

endmodule

/* design/trdb_pkg.sv */
////////////////////////////////////////
// trace compressor shared definitions
// widths, instruction decode masks,
// packet formats, structs and payload
////////////////////////////////////////
package trdb_pkg;

    localparam int XLEN           = 32;
    localparam int ILEN           = 32;
    localparam int CAUSELEN       = 5;
    localparam int PRIVLEN        = 3;
    localparam int BRANCH_MAP_LEN = 24;

    // conditional branches
    localparam logic [ILEN-1:0] MASK_BEQ   = 32'h0000_707f;
    localparam logic [ILEN-1:0] MATCH_BEQ  = 32'h0000_0063;
    localparam logic [ILEN-1:0] MASK_BNE   = 32'h0000_707f;
    localparam logic [ILEN-1:0] MATCH_BNE  = 32'h0000_1063;
    localparam logic [ILEN-1:0] MASK_BLT   = 32'h0000_707f;
    localparam logic [ILEN-1:0] MATCH_BLT  = 32'h0000_4063;
    localparam logic [ILEN-1:0] MASK_BGE   = 32'h0000_707f;
    localparam logic [ILEN-1:0] MATCH_BGE  = 32'h0000_5063;
    localparam logic [ILEN-1:0] MASK_BLTU  = 32'h0000_707f;
    localparam logic [ILEN-1:0] MATCH_BLTU = 32'h0000_6063;
    localparam logic [ILEN-1:0] MASK_BGEU  = 32'h0000_707f;
    localparam logic [ILEN-1:0] MATCH_BGEU = 32'h0000_7063;

    // jumps whose target cannot be inferred from the program
    localparam logic [ILEN-1:0] MASK_JALR  = 32'h0000_707f;
    localparam logic [ILEN-1:0] MATCH_JALR = 32'h0000_0067;
    localparam logic [ILEN-1:0] MASK_MRET  = 32'hffff_ffff;
    localparam logic [ILEN-1:0] MATCH_MRET = 32'h3020_0073;
    localparam logic [ILEN-1:0] MASK_SRET  = 32'hffff_ffff;
    localparam logic [ILEN-1:0] MATCH_SRET = 32'h1020_0073;
    localparam logic [ILEN-1:0] MASK_URET  = 32'hffff_ffff;
    localparam logic [ILEN-1:0] MATCH_URET = 32'h0020_0073;

    typedef enum logic [1:0] {
        F_BRANCH = 2'd1,
        F_SYNC   = 2'd2,
        F_EXC    = 2'd3
    } trdb_format_t;

    // one retirement report from the core
    typedef struct packed {
        logic                valid;
        logic                exception;
        logic                interrupt;
        logic [CAUSELEN-1:0] cause;
        logic [PRIVLEN-1:0]  priv;
        logic [XLEN-1:0]     iaddr;
        logic [ILEN-1:0]     instr;
        logic                compressed;
    } trdb_instr_t;

    // classified instruction, relative to the previous traced one
    typedef struct packed {
        logic                traced;
        logic                exception;
        logic                interrupt;
        logic [CAUSELEN-1:0] cause;
        logic [PRIVLEN-1:0]  priv;
        logic [XLEN-1:0]     iaddr;
        logic                need_sync;
        logic                after_udisc;
        logic                record;
        logic                taken;
    } trdb_retired_t;

    // bit k of map is the k-th recorded branch, 1 means taken
    typedef struct packed {
        logic [4:0]                count;
        logic [BRANCH_MAP_LEN-1:0] map;
        logic                      pad;
    } trdb_branch_view_t;

    typedef struct packed {
        logic                interrupt;
        logic [CAUSELEN-1:0] cause;
        logic [PRIVLEN-1:0]  priv;
        logic [20:0]         pad;
    } trdb_exc_view_t;

    // format field selects the view
    typedef union packed {
        trdb_branch_view_t branch;
        trdb_exc_view_t    exc;
    } trdb_payload_u;

    // header word is format and payload, second word is the address
    typedef struct packed {
        trdb_format_t    format;
        trdb_payload_u   payload;
        logic [XLEN-1:0] addr;
    } trdb_packet_t;

endpackage

/* design/trdb_retire_stage.sv */
////////////////////////////////////////
// input stage: registers the core
// report, decodes branches and jumps,
// keeps previous traced instruction
////////////////////////////////////////
module trdb_retire_stage (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  trdb_pkg::trdb_instr_t   instr_i,
    input  logic                    trace_enable_i,
    output trdb_pkg::trdb_retired_t retired_o
);
    import trdb_pkg::*;

    logic               valid_q;
    logic               enable_q;
    trdb_instr_t        instr_q;

    // state of the previous traced instruction
    logic               prev_traced_q;
    logic               prev_branch_q;
    logic               prev_udisc_q;
    logic               prev_exc_q;
    logic [PRIVLEN-1:0] prev_priv_q;
    logic               prev_compressed_q;
    logic [XLEN-1:0]    prev_iaddr_q;

    logic               traced;
    logic               is_branch;
    logic               is_udisc;
    logic [XLEN-1:0]    seq_iaddr;

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= 1'b0;
            enable_q <= 1'b0;
        end else begin
            valid_q  <= instr_i.valid;
            enable_q <= trace_enable_i;
        end
    end

    always_ff @(posedge clk_i) begin
        instr_q <= instr_i;
    end

    assign traced = valid_q && enable_q;

    always_comb begin
        is_branch = ((instr_q.instr & MASK_BEQ)  == MATCH_BEQ)  ||
                    ((instr_q.instr & MASK_BNE)  == MATCH_BNE)  ||
                    ((instr_q.instr & MASK_BLT)  == MATCH_BLT)  ||
                    ((instr_q.instr & MASK_BGE)  == MATCH_BGE)  ||
                    ((instr_q.instr & MASK_BLTU) == MATCH_BLTU) ||
                    ((instr_q.instr & MASK_BGEU) == MATCH_BGEU);
        is_udisc  = ((instr_q.instr & MASK_JALR) == MATCH_JALR) ||
                    ((instr_q.instr & MASK_MRET) == MATCH_MRET) ||
                    ((instr_q.instr & MASK_SRET) == MATCH_SRET) ||
                    ((instr_q.instr & MASK_URET) == MATCH_URET);
    end

    // a gap in enable breaks the chain, the next traced one is first again
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            prev_traced_q <= 1'b0;
            prev_branch_q <= 1'b0;
            prev_udisc_q  <= 1'b0;
            prev_exc_q    <= 1'b0;
            prev_priv_q   <= PRIVLEN'(3);
        end else if (!enable_q) begin
            prev_traced_q <= 1'b0;
        end else if (valid_q) begin
            prev_traced_q <= 1'b1;
            prev_branch_q <= is_branch;
            prev_udisc_q  <= is_udisc;
            prev_exc_q    <= instr_q.exception;
            prev_priv_q   <= instr_q.priv;
        end
    end

    always_ff @(posedge clk_i) begin
        if (traced) begin
            prev_iaddr_q      <= instr_q.iaddr;
            prev_compressed_q <= instr_q.compressed;
        end
    end

    assign seq_iaddr = prev_iaddr_q + (prev_compressed_q ? XLEN'(2) : XLEN'(4));

    always_comb begin
        retired_o.traced      = traced;
        retired_o.exception   = instr_q.exception;
        retired_o.interrupt   = instr_q.interrupt;
        retired_o.cause       = instr_q.cause;
        retired_o.priv        = instr_q.priv;
        retired_o.iaddr       = instr_q.iaddr;
        retired_o.need_sync   = traced && (!prev_traced_q || prev_exc_q ||
                                           (instr_q.priv != prev_priv_q));
        retired_o.after_udisc = traced && prev_traced_q && prev_udisc_q && !prev_exc_q;
        retired_o.record      = traced && prev_traced_q && prev_branch_q && !prev_exc_q;
        retired_o.taken       = instr_q.iaddr != seq_iaddr;
    end

endmodule

/* design/trdb_word_serializer.sv */
////////////////////////////////////////
// word serializer: header word then
// address word under valid/ready
////////////////////////////////////////
module trdb_word_serializer (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   pkt_valid_i,
    input  trdb_pkg::trdb_packet_t pkt_i,
    output logic                   pkt_ready_o,
    output logic [31:0]            word_o,
    output logic                   word_valid_o,
    input  logic                   word_ready_i
);
    import trdb_pkg::*;

    logic         busy_q;
    logic         addr_sel_q;
    trdb_packet_t pkt_q;
    logic         take_pkt;

    // next packet may load as the address word leaves
    assign pkt_ready_o = !busy_q || (addr_sel_q && word_ready_i);
    assign take_pkt    = pkt_valid_i && pkt_ready_o;

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q     <= 1'b0;
            addr_sel_q <= 1'b0;
        end else if (take_pkt) begin
            busy_q     <= 1'b1;
            addr_sel_q <= 1'b0;
        end else if (busy_q && word_ready_i) begin
            busy_q     <= !addr_sel_q;
            addr_sel_q <= !addr_sel_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_pkt) begin
            pkt_q <= pkt_i;
        end
    end

    assign word_valid_o = busy_q;
    assign word_o       = addr_sel_q ? pkt_q.addr : {pkt_q.format, pkt_q.payload};

    a_word_stable: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        word_valid_o && !word_ready_i |=> word_valid_o && $stable(word_o)
    ) else $error("word changed while stalled");

endmodule

/* run.sh */
#!/bin/sh
# build the trace compressor testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module trdb_tb -o trdb_sim

./obj_dir/trdb_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation finished without failures"

/* tests/trdb_tb_model.svh */
////////////////////////////////////////
// reference model of the compressor,
// expected word queue and compare task
////////////////////////////////////////
`ifndef TRDB_TB_MODEL_SVH
`define TRDB_TB_MODEL_SVH

// instruction kinds as the stimulus generates them
localparam int K_OTHER  = 0;
localparam int K_BRANCH = 1;
localparam int K_JALR   = 2;
localparam int K_MRET   = 3;

logic [31:0] exp_q[$];
int          n_errors = 0;
int          n_checks = 0;

// previous traced instruction and pending branch outcomes
logic        m_prev_traced;
int          m_prev_kind;
logic        m_prev_exc;
logic [2:0]  m_prev_priv;
logic [31:0] m_prev_addr;
logic        m_prev_compressed;
logic [23:0] m_map;
int          m_count;

function automatic void model_reset();
    m_prev_traced     = 1'b0;
    m_prev_kind       = K_OTHER;
    m_prev_exc        = 1'b0;
    m_prev_priv       = 3'd3;
    m_prev_addr       = '0;
    m_prev_compressed = 1'b0;
    m_map             = '0;
    m_count           = 0;
endfunction

// one report per cycle, pushes header and address word of any packet
function automatic void trdb_expect(input logic en, input trdb_pkg::trdb_instr_t ins,
                                    input int kind);
    logic        sync;
    logic        udisc;
    logic [31:0] seq_addr;
    if (!en) begin
        m_prev_traced = 1'b0;
        return;
    end
    if (!ins.valid) begin
        return;
    end
    sync  = !m_prev_traced || m_prev_exc || (ins.priv != m_prev_priv);
    udisc = m_prev_traced && !m_prev_exc && (m_prev_kind == K_JALR || m_prev_kind == K_MRET);
    if (m_prev_traced && !m_prev_exc && m_prev_kind == K_BRANCH) begin
        seq_addr       = m_prev_addr + (m_prev_compressed ? 32'd2 : 32'd4);
        m_map[m_count] = ins.iaddr != seq_addr;
        m_count++;
    end
    if (ins.exception) begin
        exp_q.push_back({2'd3, ins.interrupt, ins.cause, ins.priv, 21'd0});
        exp_q.push_back(ins.iaddr);
    end else if (sync || udisc || m_count == 24) begin
        exp_q.push_back({(sync ? 2'd2 : 2'd1), 5'(m_count), m_map, 1'b0});
        exp_q.push_back(ins.iaddr);
        m_map   = '0;
        m_count = 0;
    end
    m_prev_traced     = 1'b1;
    m_prev_kind       = kind;
    m_prev_exc        = ins.exception;
    m_prev_priv       = ins.priv;
    m_prev_addr       = ins.iaddr;
    m_prev_compressed = ins.compressed;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

`endif

/* tests/trdb_tb.sv */
////////////////////////////////////////
// trace compressor testbench top
// clock, reset, stimulus phases,
// word compare and final report
////////////////////////////////////////
module trdb_tb;
    import trdb_pkg::*;

    localparam int DRIVE_DLY = 10;
    localparam int TIMEOUT   = 2000;

    logic        clk_i;
    logic        rst_ni;
    trdb_instr_t instr_i;
    logic        trace_enable_i;
    logic [31:0] word_o;
    logic        word_valid_o;
    logic        word_ready_i;
    logic        overflow_o;

    // 0 ready high, 1 random ready, 2 ready low
    int          ready_mode;
    logic        compare_en;
    logic [31:0] pc;

    `include "trdb_tb_model.svh"

    trace_compressor u_dut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_i        (instr_i),
        .trace_enable_i (trace_enable_i),
        .word_o         (word_o),
        .word_valid_o   (word_valid_o),
        .word_ready_i   (word_ready_i),
        .overflow_o     (overflow_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic next_cycle();
        @(posedge clk_i);
        #DRIVE_DLY;
        case (ready_mode)
            0: word_ready_i = 1'b1;
            1: word_ready_i = ($urandom_range(0, 3) != 0);
            default: word_ready_i = 1'b0;
        endcase
    endtask

    task automatic idle_cycle();
        instr_i.valid = 1'b0;
        trdb_expect(trace_enable_i, instr_i, K_OTHER);
        next_cycle();
    endtask

    task automatic issue(input int kind, input logic exc, input logic [2:0] priv);
        trdb_instr_t ins;
        logic [2:0]  funct3;
        logic        jump;
        ins.valid      = 1'b1;
        ins.exception  = exc;
        ins.interrupt  = exc & 1'($urandom_range(0, 1));
        ins.cause      = exc ? 5'($urandom_range(0, 31)) : 5'd0;
        ins.priv       = priv;
        ins.iaddr      = pc;
        ins.compressed = 1'($urandom_range(0, 1));
        // funct3 2 and 3 are not branches, fold them onto beq and bne
        funct3 = 3'($urandom_range(2, 7));
        if (funct3 < 3'd4) begin
            funct3 = funct3 - 3'd2;
        end
        case (kind)
            K_BRANCH: ins.instr = {17'($urandom), funct3, 5'($urandom), 7'h63};
            K_JALR:   ins.instr = {17'($urandom), 3'b000, 5'($urandom), 7'h67};
            K_MRET:   ins.instr = 32'h3020_0073;
            default:  ins.instr = {25'($urandom), 7'h13};
        endcase
        jump = exc || kind == K_JALR || kind == K_MRET ||
               (kind == K_BRANCH && 1'($urandom_range(0, 1)));
        pc = jump ? ($urandom & 32'hffff_fffe) : pc + (ins.compressed ? 32'd2 : 32'd4);
        instr_i = ins;
        trdb_expect(trace_enable_i, ins, kind);
        next_cycle();
    endtask

    task automatic random_instr();
        int pick;
        if ($urandom_range(0, 3) == 0) begin
            idle_cycle();
        end
        pick = $urandom_range(0, 31);
        if (pick == 0) begin
            issue(K_JALR, 1'b0, 3'd3);
        end else if (pick == 1) begin
            issue(K_MRET, 1'b0, 3'd3);
        end else if (pick == 2) begin
            issue(K_OTHER, 1'b1, 3'd3);
        end else if (pick < 16) begin
            issue(K_BRANCH, 1'b0, 3'd3);
        end else begin
            issue(K_OTHER, 1'b0, 3'd3);
        end
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        instr_i.valid = 1'b0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            n_errors++;
            $display("timeout: %0d expected words never arrived after %s", exp_q.size(), what);
        end
    endtask

    task automatic apply_reset();
        rst_ni  = 1'b0;
        instr_i = '0;
        repeat (4) next_cycle();
        rst_ni = 1'b1;
        model_reset();
    endtask

    // a word moves on the rising edge after a falling edge that sees valid and ready
    always @(negedge clk_i) begin
        if (rst_ni && compare_en && word_valid_o && word_ready_i) begin
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("unexpected word %h at %0t while nothing was expected", word_o, $time);
            end else begin
                check_value("word_o", word_o, exp_q.pop_front());
            end
        end
    end

    initial begin
        int n;
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        instr_i        = '0;
        trace_enable_i = 1'b0;
        word_ready_i   = 1'b0;
        ready_mode     = 0;
        compare_en     = 1'b1;
        pc             = 32'h0000_1000;
        void'($urandom(32'hd011_f749));
        apply_reset();
        check_value("word_valid_o", 32'(word_valid_o), 32'd0);
        check_value("overflow_o", 32'(overflow_o), 32'd0);

        // first traced instruction, then again after an enable gap
        trace_enable_i = 1'b1;
        repeat (3) issue(K_OTHER, 1'b0, 3'd3);
        trace_enable_i = 1'b0;
        idle_cycle();
        issue(K_OTHER, 1'b0, 3'd3);
        trace_enable_i = 1'b1;
        repeat (3) issue(K_OTHER, 1'b0, 3'd3);

        // full map after 24 branches
        repeat (24) begin
            if ($urandom_range(0, 3) == 0) begin
                idle_cycle();
            end
            issue(K_BRANCH, 1'b0, 3'd3);
        end
        issue(K_OTHER, 1'b0, 3'd3);

        // unpredictable jumps with pending branches
        repeat (5) issue(K_BRANCH, 1'b0, 3'd3);
        issue(K_JALR, 1'b0, 3'd3);
        issue(K_OTHER, 1'b0, 3'd3);
        repeat (3) issue(K_BRANCH, 1'b0, 3'd3);
        issue(K_MRET, 1'b0, 3'd3);
        issue(K_OTHER, 1'b0, 3'd3);
        issue(K_JALR, 1'b0, 3'd3);
        issue(K_JALR, 1'b0, 3'd3);
        issue(K_OTHER, 1'b0, 3'd3);

        // exception, resync and privilege changes
        issue(K_BRANCH, 1'b0, 3'd3);
        issue(K_OTHER, 1'b1, 3'd3);
        repeat (2) issue(K_OTHER, 1'b0, 3'd3);
        issue(K_OTHER, 1'b0, 3'd1);
        issue(K_BRANCH, 1'b0, 3'd1);
        issue(K_OTHER, 1'b0, 3'd3);
        repeat (2) issue(K_OTHER, 1'b0, 3'd3);
        // exception outside machine mode carries its own privilege
        issue(K_OTHER, 1'b1, 3'd1);
        issue(K_OTHER, 1'b0, 3'd1);
        wait_drain("directed phases");

        ready_mode = 1;
        repeat (400) random_instr();
        wait_drain("random phase");
        check_value("overflow_o", 32'(overflow_o), 32'd0);

        // back-pressure until the FIFO drops packets
        ready_mode = 2;
        compare_en = 1'b0;
        repeat (10) issue(K_JALR, 1'b0, 3'd3);
        issue(K_OTHER, 1'b0, 3'd3);
        instr_i.valid = 1'b0;
        n = 0;
        while (!overflow_o && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!overflow_o) begin
            n_errors++;
            $display("timeout: overflow_o never rose while word_ready_i was held low");
        end
        ready_mode = 0;
        repeat (30) next_cycle();
        check_value("overflow_o", 32'(overflow_o), 32'd1);
        apply_reset();
        exp_q.delete();
        check_value("word_valid_o", 32'(word_valid_o), 32'd0);
        check_value("overflow_o", 32'(overflow_o), 32'd0);
        compare_en = 1'b1;
        repeat (20) random_instr();
        wait_drain("final phase");

        $display("trdb_tb: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
